// File: hookPkg.sv
// Shared sizes for the hook renderer. NUM_PLOTTERS must equal 2**SLOT_BITS and the table holds only 2-degree steps
package hookPkg;

    // Plotter array
    localparam int NUM_PLOTTERS = 4;
    localparam int SLOT_BITS = 2;        // Plotter index width

    // Screen coordinates for the 320 x 240 display
    localparam int X_BITS = 9;
    localparam int Y_BITS = 8;

    // Angles
    localparam int ANGLE_BITS = 9;       // Degrees 0..359
    localparam int INDEX_BITS = 8;       // Step index 0..179
    localparam int STEP_COUNT = 180;
    localparam int STEP_DEGREES = 2;
    localparam int FULL_CIRCLE = 360;
    localparam int QUARTER_STEPS = 45;   // Steps per 90 degrees
    localparam int GAP_DEGREES = 30;     // Width of the left-out arc

    // Hook geometry
    localparam int RADIUS = 18;

    // Trig table scaled to hundredths
    localparam int TRIG_SCALE = 100;
    localparam int MAG_BITS = 7;

    // Coordinate words for wrap-around truncation
    typedef logic [X_BITS-1:0] xWord;
    typedef logic [Y_BITS-1:0] yWord;

endpackage

// File: trigTable.sv
// Angle index must be below 180. Magnitudes are sine and cosine times 100, rounded, with separate sign bits
`timescale 1ns/1ns

module trigTable (
    input  logic [hookPkg::INDEX_BITS-1:0] angleIndex,
    output logic [hookPkg::MAG_BITS-1:0]   sinMag,
    output logic [hookPkg::MAG_BITS-1:0]   cosMag,
    output logic                           sinNeg,
    output logic                           cosNeg
);

    // Rounded sin for 0..90 degrees in 2-degree steps
    function automatic logic [hookPkg::MAG_BITS-1:0] sinLut(input int idx);
        case (idx)
            0:  sinLut = 7'd0;
            1:  sinLut = 7'd3;
            2:  sinLut = 7'd7;
            3:  sinLut = 7'd10;
            4:  sinLut = 7'd14;
            5:  sinLut = 7'd17;
            6:  sinLut = 7'd21;
            7:  sinLut = 7'd24;
            8:  sinLut = 7'd28;
            9:  sinLut = 7'd31;
            10: sinLut = 7'd34;
            11: sinLut = 7'd37;
            12: sinLut = 7'd41;
            13: sinLut = 7'd44;
            14: sinLut = 7'd47;
            15: sinLut = 7'd50;
            16: sinLut = 7'd53;
            17: sinLut = 7'd56;
            18: sinLut = 7'd59;
            19: sinLut = 7'd62;
            20: sinLut = 7'd64;
            21: sinLut = 7'd67;
            22: sinLut = 7'd69;
            23: sinLut = 7'd72;
            24: sinLut = 7'd74;
            25: sinLut = 7'd77;
            26: sinLut = 7'd79;
            27: sinLut = 7'd81;
            28: sinLut = 7'd83;
            29: sinLut = 7'd85;
            30: sinLut = 7'd87;
            31: sinLut = 7'd88;
            32: sinLut = 7'd90;
            33: sinLut = 7'd91;
            34: sinLut = 7'd93;
            35: sinLut = 7'd94;
            36: sinLut = 7'd95;
            37: sinLut = 7'd96;
            38: sinLut = 7'd97;
            39: sinLut = 7'd98;
            40: sinLut = 7'd98;
            41: sinLut = 7'd99;
            42: sinLut = 7'd99;
            43: sinLut = 7'd100;
            44: sinLut = 7'd100;
            default: sinLut = 7'd100;   // 90 degrees
        endcase
    endfunction

    always_comb begin
        int quadrant;
        int residue;
        logic [hookPkg::MAG_BITS-1:0] lowMag;
        logic [hookPkg::MAG_BITS-1:0] highMag;
        quadrant = int'(angleIndex) / hookPkg::QUARTER_STEPS;
        residue = int'(angleIndex) - quadrant * hookPkg::QUARTER_STEPS;
        lowMag = sinLut(residue);                            // sin of angle within quadrant
        highMag = sinLut(hookPkg::QUARTER_STEPS - residue);  // cos of same
        case (quadrant)
            0: begin
                sinMag = lowMag;
                cosMag = highMag;
                sinNeg = 1'b0;
                cosNeg = 1'b0;
            end
            1: begin                // 90..178
                sinMag = highMag;
                cosMag = lowMag;
                sinNeg = 1'b0;
                cosNeg = 1'b1;
            end
            2: begin                // 180..268
                sinMag = lowMag;
                cosMag = highMag;
                sinNeg = 1'b1;
                cosNeg = 1'b1;
            end
            default: begin          // 270..358
                sinMag = highMag;
                cosMag = lowMag;
                sinNeg = 1'b1;
                cosNeg = 1'b0;
            end
        endcase
    end

endmodule

// File: arcPlotter.sv
// One hook at a time. gapAngle must be below 360 and coordinates wrap modulo the word width
`timescale 1ns/1ns

module arcPlotter (
    input  logic                           clock,
    input  logic                           resetn,
    input  logic                           start,
    input  logic                           step,
    input  logic [hookPkg::X_BITS-1:0]     startX,
    input  logic [hookPkg::Y_BITS-1:0]     startY,
    input  logic [hookPkg::ANGLE_BITS-1:0] gapAngle,
    output logic [hookPkg::X_BITS-1:0]     pointX,
    output logic [hookPkg::Y_BITS-1:0]     pointY,
    output logic                           plotPoint,
    output logic                           lastPoint,
    output logic                           active
);

    logic [hookPkg::X_BITS-1:0]     heldX;
    logic [hookPkg::Y_BITS-1:0]     heldY;
    logic [hookPkg::ANGLE_BITS-1:0] heldGap;
    logic [hookPkg::INDEX_BITS-1:0] angleIndex;

    logic [hookPkg::MAG_BITS-1:0] sinMag;
    logic [hookPkg::MAG_BITS-1:0] cosMag;
    logic                         sinNeg;
    logic                         cosNeg;

    int angleDeg;
    int gapDist;
    int offsetX;
    int offsetY;

    trigTable table0 (
        .angleIndex(angleIndex),
        .sinMag(sinMag),
        .cosMag(cosMag),
        .sinNeg(sinNeg),
        .cosNeg(cosNeg)
    );

    // Angle counter and run flag
    always_ff @(posedge clock) begin
        if (!resetn) begin
            active <= 1'b0;
            angleIndex <= '0;
        end else if (start) begin
            active <= 1'b1;
            angleIndex <= '0;
        end else if (step) begin
            angleIndex <= angleIndex + 1'b1;
            if (lastPoint) begin
                active <= 1'b0;   // Final step taken
            end
        end
    end

    // Command fields, held for the whole hook
    always_ff @(posedge clock) begin
        if (start) begin
            heldX <= startX;
            heldY <= startY;
            heldGap <= gapAngle;
        end
    end

    always_comb begin
        angleDeg = int'(angleIndex) * hookPkg::STEP_DEGREES;

        // Forward distance from gap start to this angle
        gapDist = angleDeg + hookPkg::FULL_CIRCLE - int'(heldGap);
        if (gapDist >= hookPkg::FULL_CIRCLE) begin
            gapDist = gapDist - hookPkg::FULL_CIRCLE;
        end
        plotPoint = gapDist >= hookPkg::GAP_DEGREES;

        // Magnitudes truncate here, so the signed result truncates toward zero
        offsetX = hookPkg::RADIUS * int'(cosMag) / hookPkg::TRIG_SCALE;
        offsetY = hookPkg::RADIUS * int'(sinMag) / hookPkg::TRIG_SCALE;
        if (cosNeg) begin
            offsetX = -offsetX;
        end
        if (sinNeg) begin
            offsetY = -offsetY;
        end

        pointX = hookPkg::xWord'(int'(heldX) + offsetX);   // Wraps modulo 512
        pointY = hookPkg::yWord'(int'(heldY) + offsetY);   // Wraps modulo 256
        lastPoint = int'(angleIndex) == hookPkg::STEP_COUNT - 1;
    end

endmodule

// File: hookDispatcher.sv
// Commands to a busy slot are dropped without notice. The command fields stay valid only in the cycle of the start pulse
`timescale 1ns/1ns

module hookDispatcher (
    input  logic                             clock,
    input  logic                             resetn,
    input  logic                             drawStart,
    input  logic [hookPkg::SLOT_BITS-1:0]    drawSlot,
    input  logic [hookPkg::X_BITS-1:0]       centerX,
    input  logic [hookPkg::Y_BITS-1:0]       centerY,
    input  logic [hookPkg::ANGLE_BITS-1:0]   gapAngle,
    input  logic [hookPkg::NUM_PLOTTERS-1:0] plotterActive,
    output logic [hookPkg::NUM_PLOTTERS-1:0] startPulse,
    output logic [hookPkg::X_BITS-1:0]       latchedX,
    output logic [hookPkg::Y_BITS-1:0]       latchedY,
    output logic [hookPkg::ANGLE_BITS-1:0]   latchedGap,
    output logic [hookPkg::NUM_PLOTTERS-1:0] busy
);

    logic accept;

    // A slot counts as busy from the start pulse on
    assign busy = plotterActive | startPulse;
    assign accept = drawStart && !busy[drawSlot];

    // One-hot start toward the chosen plotter
    always_ff @(posedge clock) begin
        if (!resetn) begin
            startPulse <= '0;
        end else begin
            startPulse <= '0;
            if (accept) begin
                startPulse[drawSlot] <= 1'b1;
            end
        end
    end

    // Shared command bus, sampled by the plotter on its start
    always_ff @(posedge clock) begin
        if (accept) begin
            latchedX <= centerX;
            latchedY <= centerY;
            latchedGap <= gapAngle;
        end
    end

endmodule

// File: pixelMerger.sv
// Grants one plotter step per cycle. No back-pressure from the pixel port, which must take every write
`timescale 1ns/1ns

module pixelMerger (
    input  logic                                            clock,
    input  logic                                            resetn,
    input  logic [hookPkg::NUM_PLOTTERS-1:0]                plotterActive,
    input  logic [hookPkg::NUM_PLOTTERS-1:0]                plotFlags,
    input  logic [hookPkg::NUM_PLOTTERS-1:0]                lastFlags,
    input  logic [hookPkg::NUM_PLOTTERS*hookPkg::X_BITS-1:0] pointXs,
    input  logic [hookPkg::NUM_PLOTTERS*hookPkg::Y_BITS-1:0] pointYs,
    output logic [hookPkg::NUM_PLOTTERS-1:0]                stepPulse,
    output logic                                            pixelWrite,
    output logic [hookPkg::X_BITS-1:0]                      pixelX,
    output logic [hookPkg::Y_BITS-1:0]                      pixelY,
    output logic [hookPkg::SLOT_BITS-1:0]                   pixelSlot,
    output logic                                            hookDone,
    output logic [hookPkg::SLOT_BITS-1:0]                   doneSlot
);

    logic [hookPkg::SLOT_BITS-1:0] lastGrant;
    logic [hookPkg::SLOT_BITS-1:0] grantIdx;
    logic                          grantValid;

    // Round-robin search starting just past the last grant
    always_comb begin
        logic [hookPkg::SLOT_BITS-1:0] candidate;
        grantValid = 1'b0;
        grantIdx = lastGrant;
        stepPulse = '0;
        for (int i = 1; i <= hookPkg::NUM_PLOTTERS; i++) begin
            candidate = lastGrant + i[hookPkg::SLOT_BITS-1:0];   // Wraps, last grant checked last
            if (!grantValid && plotterActive[candidate]) begin
                grantValid = 1'b1;
                grantIdx = candidate;
            end
        end
        if (grantValid) begin
            stepPulse[grantIdx] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            lastGrant <= '1;      // First search begins at plotter 0
            pixelWrite <= 1'b0;
            hookDone <= 1'b0;
        end else begin
            pixelWrite <= grantValid && plotFlags[grantIdx];
            hookDone <= grantValid && lastFlags[grantIdx];
            if (grantValid) begin
                lastGrant <= grantIdx;
            end
        end
    end

    // Pixel of the granted step
    always_ff @(posedge clock) begin
        pixelX <= pointXs[grantIdx*hookPkg::X_BITS +: hookPkg::X_BITS];
        pixelY <= pointYs[grantIdx*hookPkg::Y_BITS +: hookPkg::Y_BITS];
        pixelSlot <= grantIdx;
    end

    // Done comes with the last pixel, so it names the same slot
    assign doneSlot = pixelSlot;

endmodule

// File: hookRenderer.sv
// Hook drawing top level. Colour, frame buffer and VGA timing live outside this block
`timescale 1ns/1ns

module hookRenderer (
    input  logic                             clock,
    input  logic                             resetn,
    input  logic                             drawStart,
    input  logic [hookPkg::SLOT_BITS-1:0]    drawSlot,
    input  logic [hookPkg::X_BITS-1:0]       centerX,
    input  logic [hookPkg::Y_BITS-1:0]       centerY,
    input  logic [hookPkg::ANGLE_BITS-1:0]   gapAngle,
    output logic [hookPkg::NUM_PLOTTERS-1:0] busy,
    output logic                             pixelWrite,
    output logic [hookPkg::X_BITS-1:0]       pixelX,
    output logic [hookPkg::Y_BITS-1:0]       pixelY,
    output logic [hookPkg::SLOT_BITS-1:0]    pixelSlot,
    output logic                             hookDone,
    output logic [hookPkg::SLOT_BITS-1:0]    doneSlot
);

    logic [hookPkg::NUM_PLOTTERS-1:0] startPulse;
    logic [hookPkg::NUM_PLOTTERS-1:0] stepPulse;
    logic [hookPkg::NUM_PLOTTERS-1:0] plotterActive;
    logic [hookPkg::NUM_PLOTTERS-1:0] plotFlags;
    logic [hookPkg::NUM_PLOTTERS-1:0] lastFlags;

    logic [hookPkg::X_BITS-1:0]     latchedX;
    logic [hookPkg::Y_BITS-1:0]     latchedY;
    logic [hookPkg::ANGLE_BITS-1:0] latchedGap;

    // Plotter points, packed with plotter 0 in the low bits
    logic [hookPkg::NUM_PLOTTERS*hookPkg::X_BITS-1:0] pointXs;
    logic [hookPkg::NUM_PLOTTERS*hookPkg::Y_BITS-1:0] pointYs;

    hookDispatcher dispatcher0 (
        .clock(clock),
        .resetn(resetn),
        .drawStart(drawStart),
        .drawSlot(drawSlot),
        .centerX(centerX),
        .centerY(centerY),
        .gapAngle(gapAngle),
        .plotterActive(plotterActive),
        .startPulse(startPulse),
        .latchedX(latchedX),
        .latchedY(latchedY),
        .latchedGap(latchedGap),
        .busy(busy)
    );

    for (genvar p = 0; p < hookPkg::NUM_PLOTTERS; p++) begin : plotters
        arcPlotter plotter (
            .clock(clock),
            .resetn(resetn),
            .start(startPulse[p]),
            .step(stepPulse[p]),
            .startX(latchedX),
            .startY(latchedY),
            .gapAngle(latchedGap),
            .pointX(pointXs[p*hookPkg::X_BITS +: hookPkg::X_BITS]),
            .pointY(pointYs[p*hookPkg::Y_BITS +: hookPkg::Y_BITS]),
            .plotPoint(plotFlags[p]),
            .lastPoint(lastFlags[p]),
            .active(plotterActive[p])
        );
    end

    pixelMerger merger0 (
        .clock(clock),
        .resetn(resetn),
        .plotterActive(plotterActive),
        .plotFlags(plotFlags),
        .lastFlags(lastFlags),
        .pointXs(pointXs),
        .pointYs(pointYs),
        .stepPulse(stepPulse),
        .pixelWrite(pixelWrite),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelSlot(pixelSlot),
        .hookDone(hookDone),
        .doneSlot(doneSlot)
    );

endmodule

// File: tbClock.sv
// Free-running testbench clock with a 100 ns period. Reset is held low for the first 4 rising edges
`timescale 1ns/1ns

module tbClock (
    output logic clock,
    output logic resetn
);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;   // Half period
    end

    initial begin
        resetn = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);             // Release away from the sampling edge
        resetn = 1'b1;
    end

endmodule

// File: hookRendererTb.sv
// Run from the project root so hook_stim.txt is found. Expected sums there assume RADIUS 18
`timescale 1ns/1ns

module hookRendererTb;

    logic                             clock;
    logic                             resetn;
    logic                             drawStart;
    logic [hookPkg::SLOT_BITS-1:0]    drawSlot;
    logic [hookPkg::X_BITS-1:0]       centerX;
    logic [hookPkg::Y_BITS-1:0]       centerY;
    logic [hookPkg::ANGLE_BITS-1:0]   gapAngle;
    logic [hookPkg::NUM_PLOTTERS-1:0] busy;
    logic                             pixelWrite;
    logic [hookPkg::X_BITS-1:0]       pixelX;
    logic [hookPkg::Y_BITS-1:0]       pixelY;
    logic [hookPkg::SLOT_BITS-1:0]    pixelSlot;
    logic                             hookDone;
    logic [hookPkg::SLOT_BITS-1:0]    doneSlot;

    // Command table, one entry per stim line
    int cmdIdle[$];
    int cmdWait[$];
    int cmdSlot[$];
    int cmdX[$];
    int cmdY[$];
    int cmdGap[$];
    int cmdAccept[$];
    int cmdLatency[$];
    int expCount[$];
    int expXSum[$];
    int expYSum[$];
    int expFirstX[$];
    int expFirstY[$];
    int waitTotal = 0;

    // Hook in flight per slot
    int pending [hookPkg::NUM_PLOTTERS];      // Command index, -1 when idle
    int pixCount [hookPkg::NUM_PLOTTERS];
    int xSum [hookPkg::NUM_PLOTTERS];
    int ySum [hookPkg::NUM_PLOTTERS];
    int firstX [hookPkg::NUM_PLOTTERS];
    int firstY [hookPkg::NUM_PLOTTERS];
    int startCycle [hookPkg::NUM_PLOTTERS];
    int doneTotal [hookPkg::NUM_PLOTTERS];
    int acceptTotal [hookPkg::NUM_PLOTTERS];

    int   cycleCount = 0;
    int   cycleLimit = 1000;
    int   errorCount = 0;
    int   checkCount = 0;
    logic commandSeen = 1'b0;

    tbClock clockGen0 (.clock(clock), .resetn(resetn));

    hookRenderer dut0 (
        .clock(clock), .resetn(resetn), .drawStart(drawStart), .drawSlot(drawSlot),
        .centerX(centerX), .centerY(centerY), .gapAngle(gapAngle), .busy(busy),
        .pixelWrite(pixelWrite), .pixelX(pixelX), .pixelY(pixelY), .pixelSlot(pixelSlot),
        .hookDone(hookDone), .doneSlot(doneSlot)
    );

    // Watchdog
    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Errors found");
            $finish;
        end
    end

    task automatic checkValue(input string what, input int got, input int expected);
        checkCount++;
        if (got != expected) begin
            errorCount++;
            $display("error at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic loadStimulus();
        int fd;
        int n;
        int f [13];
        string line;
        fd = $fopen("hook_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file hook_stim.txt");
            errorCount++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;   // Column notes
            end
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
            if (n == 13) begin
                cmdIdle.push_back(f[0]);
                cmdWait.push_back(f[1]);
                cmdSlot.push_back(f[2]);
                cmdX.push_back(f[3]);
                cmdY.push_back(f[4]);
                cmdGap.push_back(f[5]);
                cmdAccept.push_back(f[6]);
                cmdLatency.push_back(f[7]);
                expCount.push_back(f[8]);
                expXSum.push_back(f[9]);
                expYSum.push_back(f[10]);
                expFirstX.push_back(f[11]);
                expFirstY.push_back(f[12]);
                waitTotal += f[1];
            end else if (n > 0) begin
                $display("Stimulus line could not be parsed: %s", line);
                errorCount++;
            end
        end
        $fclose(fd);
    endtask

    task automatic clearSlot(input int s);
        pending[s] = -1;
        pixCount[s] = 0;
        xSum[s] = 0;
        ySum[s] = 0;
    endtask

    // Sampled on the falling edge, where DUT outputs are settled
    task automatic watchOutputs();
        int s;
        int c;
        if (!commandSeen) begin
            checkValue("busy before first command", int'(busy), 0);
            checkValue("pixelWrite before first command", int'(pixelWrite), 0);
            checkValue("hookDone before first command", int'(hookDone), 0);
        end
        if (pixelWrite) begin
            s = int'(pixelSlot);
            if (pending[s] < 0) begin
                errorCount++;
                $display("error at time %0t: slot %0d wrote a pixel with no hook", $time, s);
            end
            if (pixCount[s] == 0) begin
                firstX[s] = int'(pixelX);
                firstY[s] = int'(pixelY);
            end
            pixCount[s]++;
            xSum[s] += int'(pixelX);
            ySum[s] += int'(pixelY);
        end
        if (hookDone) begin   // Last pixel of the hook was taken above
            s = int'(doneSlot);
            c = pending[s];
            if (c < 0) begin
                errorCount++;
                $display("error at time %0t: hookDone on slot %0d with no hook", $time, s);
            end else begin
                checkValue($sformatf("slot %0d pixel count", s), pixCount[s], expCount[c]);
                checkValue($sformatf("slot %0d X sum", s), xSum[s], expXSum[c]);
                checkValue($sformatf("slot %0d Y sum", s), ySum[s], expYSum[c]);
                checkValue($sformatf("slot %0d first X", s), firstX[s], expFirstX[c]);
                checkValue($sformatf("slot %0d first Y", s), firstY[s], expFirstY[c]);
                if (cmdLatency[c] != 0) begin
                    checkValue($sformatf("slot %0d done latency", s),
                               cycleCount - startCycle[s], cmdLatency[c]);
                end
                doneTotal[s]++;
            end
            clearSlot(s);
        end
    endtask

    task automatic nextCycle();
        @(negedge clock);
        watchOutputs();
    endtask

    task automatic issueCommand(input int i);
        int s;
        int x;
        int y;
        int g;
        s = cmdSlot[i];
        x = cmdX[i];
        y = cmdY[i];
        g = cmdGap[i];
        if (cmdIdle[i] != 0) begin
            while (busy != '0) begin
                nextCycle();
            end
        end
        repeat (cmdWait[i]) begin
            nextCycle();
        end
        checkValue($sformatf("slot %0d busy before command %0d", s, i), int'(busy[s]),
                   (cmdAccept[i] == 0) ? 1 : 0);
        drawStart = 1'b1;
        drawSlot = s[hookPkg::SLOT_BITS-1:0];
        centerX = x[hookPkg::X_BITS-1:0];
        centerY = y[hookPkg::Y_BITS-1:0];
        gapAngle = g[hookPkg::ANGLE_BITS-1:0];
        commandSeen = 1'b1;
        if (cmdAccept[i] != 0) begin
            pending[s] = i;
            startCycle[s] = cycleCount + 1;   // Edge that samples the strobe
            acceptTotal[s]++;
        end
        nextCycle();
        drawStart = 1'b0;
        checkValue($sformatf("slot %0d busy after command %0d", s, i), int'(busy[s]), 1);
    endtask

    initial begin
        int i;
        int s;
        drawStart = 1'b0;
        drawSlot = '0;
        centerX = '0;
        centerY = '0;
        gapAngle = '0;
        for (s = 0; s < hookPkg::NUM_PLOTTERS; s++) begin
            clearSlot(s);
            doneTotal[s] = 0;
            acceptTotal[s] = 0;
        end
        loadStimulus();
        if (cmdSlot.size() == 0) begin
            $display("No commands were loaded from the stimulus file");
            errorCount++;
        end
        cycleLimit = cmdSlot.size() * hookPkg::STEP_COUNT * hookPkg::NUM_PLOTTERS
                     + waitTotal + 500;
        wait (resetn == 1'b1);
        for (i = 0; i < cmdSlot.size(); i++) begin
            issueCommand(i);
        end
        while (busy != '0) begin
            nextCycle();
        end
        repeat (5) nextCycle();   // Catch stray pixels after the last hook
        for (s = 0; s < hookPkg::NUM_PLOTTERS; s++) begin
            checkValue($sformatf("slot %0d hookDone count", s), doneTotal[s], acceptTotal[s]);
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: hook_stim.txt
# idle wait slot cx cy gap accept latency | count xSum ySum firstX firstY
# idle=1 waits for all plotters free, latency 0 skips that check, rejected lines expect nothing
1  5 0 160 120   0 1 181 165 26148 19742 175 129
1  2 1 100  60  90 1 181 165 16558  9648 118  60
1  2 2 200 150 345 1 181 165 32740 24750 217 155
0 10 2  40  40   0 0   0   0     0     0   0   0
1  2 3  60 200 180 1 181 165 10152 33058  78 200
1  2 0 250 100 271 1 181 165 41183 16749 268 100
1  2 1 500 254 340 1 181 165 64833 20944   5   1
1  2 2   4   3 150 1 181 165 31629 20140  22   3
1  2 0  60 200 180 1   0 165 10152 33058  78 200
0  0 1 160 120   0 1   0 165 26148 19742 175 129
0  0 2 250 100 271 1   0 165 41183 16749 268 100
0  0 3 500 254 340 1   0 165 64833 20944   5   1
0  3 1  10  10  10 0   0   0     0     0   0   0
1  2 1 100  60  90 1 181 165 16558  9648 118  60
1  2 3   4   3 150 1   0 165 31629 20140  22   3
0  0 2 200 150 345 1   0 165 32740 24750 217 155
0  0 1 250 100 271 1   0 165 41183 16749 268 100
0  0 0 100  60  90 1   0 165 16558  9648 118  60
0  1 0  30  30  30 0   0   0     0     0   0   0

// File: all.f
hookPkg.sv
trigTable.sv
arcPlotter.sv
hookDispatcher.sv
pixelMerger.sv
hookRenderer.sv
tbClock.sv
hookRendererTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns
TOP       = hookRendererTb
FILELIST  = all.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) *.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
